//--- hw/datapathPkg.sv
package datapathPkg;

        localparam int dataWidth = 32;
        localparam int regCount = 16;
        localparam int regIndexWidth = 4;
        localparam int sourceCount = 24;
        localparam int sourceWidth = 5;
        localparam int opWidth = 5;
        localparam int shiftWidth = 5;

        // Immediate field in the low bits of IR
        localparam int constWidth = 19;

        // Bus driver indices, general registers first
        typedef enum logic [sourceWidth-1:0] {
                r0Src = 5'd0, r1Src, r2Src, r3Src,
                r4Src, r5Src, r6Src, r7Src,
                r8Src, r9Src, r10Src, r11Src,
                r12Src, r13Src, r14Src, r15Src,
                hiSrc, loSrc, zHighSrc, zLowSrc,
                pcSrc, mdrSrc, inPortSrc, constSrc,
                noneSrc = 5'd31
        } busSource;

        typedef enum logic [opWidth-1:0] {
                opAdd,
                opSub,
                opAnd,
                opOr,
                opShl,
                opShr,
                opNeg,
                opNot,
                opMul
        } aluOp;

endpackage

//--- hw/registerFile.sv
`timescale 1ns/1ns

module registerFile (
        input  logic                                Clock,
        input  logic                                arstN,
        input  logic [datapathPkg::regCount-1:0]    regIn,
        input  logic [datapathPkg::dataWidth-1:0]   busData,
        output logic [datapathPkg::dataWidth-1:0]   regData [0:datapathPkg::regCount-1]
);

        // R0 behaves like any other register
        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        for (int i = 0; i < datapathPkg::regCount; i++) begin
                                regData[i] <= '0;
                        end
                end else begin
                        for (int i = 0; i < datapathPkg::regCount; i++) begin
                                if (regIn[i]) begin
                                        regData[i] <= busData;
                                end
                        end
                end
        end

endmodule

//--- hw/busEncoder.sv
`timescale 1ns/1ns

module busEncoder (
        input  logic [datapathPkg::sourceCount-1:0] outEnable,
        input  logic [datapathPkg::dataWidth-1:0]   regData [0:datapathPkg::regCount-1],
        input  logic [datapathPkg::dataWidth-1:0]   hiData,
        input  logic [datapathPkg::dataWidth-1:0]   loData,
        input  logic [datapathPkg::dataWidth-1:0]   zHigh,
        input  logic [datapathPkg::dataWidth-1:0]   zLow,
        input  logic [datapathPkg::dataWidth-1:0]   pcData,
        input  logic [datapathPkg::dataWidth-1:0]   mdrData,
        input  logic [datapathPkg::dataWidth-1:0]   inPort,
        input  logic [datapathPkg::dataWidth-1:0]   constData,
        output logic [datapathPkg::dataWidth-1:0]   busData
);

        datapathPkg::busSource source;

        // Lowest set enable wins, scan from the top down
        always_comb begin
                source = datapathPkg::noneSrc;
                for (int i = datapathPkg::sourceCount - 1; i >= 0; i--) begin
                        if (outEnable[i]) begin
                                source = datapathPkg::busSource'(i[datapathPkg::sourceWidth-1:0]);
                        end
                end
        end

        always_comb begin
                case (source)
                        datapathPkg::hiSrc:     busData = hiData;
                        datapathPkg::loSrc:     busData = loData;
                        datapathPkg::zHighSrc:  busData = zHigh;
                        datapathPkg::zLowSrc:   busData = zLow;
                        datapathPkg::pcSrc:     busData = pcData;
                        datapathPkg::mdrSrc:    busData = mdrData;
                        datapathPkg::inPortSrc: busData = inPort;
                        datapathPkg::constSrc:  busData = constData;
                        datapathPkg::noneSrc:   busData = '0;
                        default: begin
                                // General registers occupy the low indices
                                if (source < datapathPkg::regCount) begin
                                        busData = regData[source[datapathPkg::regIndexWidth-1:0]];
                                end else begin
                                        busData = '0;
                                end
                        end
                endcase
        end

endmodule

//--- hw/memoryDataRegister.sv
`timescale 1ns/1ns

module memoryDataRegister (
        input  logic                              Clock,
        input  logic                              arstN,
        input  logic                              mdrIn,
        input  logic                              read,
        input  logic [datapathPkg::dataWidth-1:0] memData,
        input  logic [datapathPkg::dataWidth-1:0] busData,
        output logic [datapathPkg::dataWidth-1:0] mdrData
);

        // Memory word when reading, bus otherwise
        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        mdrData <= '0;
                end else if (mdrIn) begin
                        if (read) begin
                                mdrData <= memData;
                        end else begin
                                mdrData <= busData;
                        end
                end
        end

endmodule

//--- hw/specialRegisters.sv
`timescale 1ns/1ns

module specialRegisters (
        input  logic                                  Clock,
        input  logic                                  arstN,
        input  logic                                  pcIn,
        input  logic                                  incPc,
        input  logic                                  irIn,
        input  logic                                  marIn,
        input  logic                                  yIn,
        input  logic                                  zIn,
        input  logic                                  hiIn,
        input  logic                                  loIn,
        input  logic [datapathPkg::dataWidth-1:0]     busData,
        input  logic [2*datapathPkg::dataWidth-1:0]   aluResult,
        output logic [datapathPkg::dataWidth-1:0]     pcData,
        output logic [datapathPkg::dataWidth-1:0]     irData,
        output logic [datapathPkg::dataWidth-1:0]     marData,
        output logic [datapathPkg::dataWidth-1:0]     yData,
        output logic [datapathPkg::dataWidth-1:0]     zHigh,
        output logic [datapathPkg::dataWidth-1:0]     zLow,
        output logic [datapathPkg::dataWidth-1:0]     hiData,
        output logic [datapathPkg::dataWidth-1:0]     loData,
        output logic [datapathPkg::dataWidth-1:0]     constData
);

        logic [2*datapathPkg::dataWidth-1:0] zData;

        // A bus load overrides the increment
        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        pcData <= '0;
                end else if (pcIn) begin
                        pcData <= busData;
                end else if (incPc) begin
                        pcData <= pcData + datapathPkg::dataWidth'(1);
                end
        end

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        irData <= '0;
                        marData <= '0;
                        yData <= '0;
                        hiData <= '0;
                        loData <= '0;
                end else begin
                        if (irIn) begin
                                irData <= busData;
                        end
                        if (marIn) begin
                                marData <= busData;
                        end
                        if (yIn) begin
                                yData <= busData;
                        end
                        if (hiIn) begin
                                hiData <= busData;
                        end
                        if (loIn) begin
                                loData <= busData;
                        end
                end
        end

        // Z takes the full ALU result
        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        zData <= '0;
                end else if (zIn) begin
                        zData <= aluResult;
                end
        end

        assign zHigh = zData[2*datapathPkg::dataWidth-1:datapathPkg::dataWidth];
        assign zLow = zData[datapathPkg::dataWidth-1:0];

        // Sign-extended immediate from IR
        assign constData = {{(datapathPkg::dataWidth - datapathPkg::constWidth)
                {irData[datapathPkg::constWidth-1]}}, irData[datapathPkg::constWidth-1:0]};

endmodule

//--- hw/alu.sv
`timescale 1ns/1ns

module alu (
        input  datapathPkg::aluOp                     operation,
        input  logic [datapathPkg::dataWidth-1:0]     a,
        input  logic [datapathPkg::dataWidth-1:0]     b,
        output logic [2*datapathPkg::dataWidth-1:0]   result
);

        logic signed [2*datapathPkg::dataWidth-1:0] product;
        logic [datapathPkg::dataWidth-1:0]          word;
        logic [datapathPkg::shiftWidth-1:0]         shiftAmount;

        assign shiftAmount = b[datapathPkg::shiftWidth-1:0];

        // Both operands sign-extended before multiplying
        assign product = $signed(a) * $signed(b);

        // Single-word results, neg and not act on the bus operand
        always_comb begin
                case (operation)
                        datapathPkg::opAdd: word = a + b;
                        datapathPkg::opSub: word = a - b;
                        datapathPkg::opAnd: word = a & b;
                        datapathPkg::opOr:  word = a | b;
                        datapathPkg::opShl: word = a << shiftAmount;
                        datapathPkg::opShr: word = a >> shiftAmount;
                        datapathPkg::opNeg: word = -b;
                        datapathPkg::opNot: word = ~b;
                        default:            word = '0;
                endcase
        end

        // High word stays zero except for mul
        always_comb begin
                if (operation == datapathPkg::opMul) begin
                        result = product;
                end else begin
                        result = {{datapathPkg::dataWidth{1'b0}}, word};
                end
        end

endmodule

//--- hw/datapath.sv
`timescale 1ns/1ns

module datapath (
        input  logic                              Clock,
        input  logic                              arstN,
        input  logic [datapathPkg::regCount-1:0]  regIn,
        input  logic [datapathPkg::regCount-1:0]  regOut,
        input  logic                              hiOut,
        input  logic                              loOut,
        input  logic                              zHighOut,
        input  logic                              zLowOut,
        input  logic                              pcOut,
        input  logic                              mdrOut,
        input  logic                              inPortOut,
        input  logic                              cOut,
        input  logic                              pcIn,
        input  logic                              incPc,
        input  logic                              irIn,
        input  logic                              marIn,
        input  logic                              yIn,
        input  logic                              zIn,
        input  logic                              hiIn,
        input  logic                              loIn,
        input  logic                              mdrIn,
        input  logic                              read,
        input  datapathPkg::aluOp                 operation,
        input  logic [datapathPkg::dataWidth-1:0] memData,
        input  logic [datapathPkg::dataWidth-1:0] inPort,
        output logic [datapathPkg::dataWidth-1:0] busData,
        output logic [datapathPkg::dataWidth-1:0] marData,
        output logic [datapathPkg::dataWidth-1:0] irData
);

        logic [datapathPkg::sourceCount-1:0]   outEnable;
        logic [datapathPkg::dataWidth-1:0]     regData [0:datapathPkg::regCount-1];
        logic [datapathPkg::dataWidth-1:0]     hiData;
        logic [datapathPkg::dataWidth-1:0]     loData;
        logic [datapathPkg::dataWidth-1:0]     zHigh;
        logic [datapathPkg::dataWidth-1:0]     zLow;
        logic [datapathPkg::dataWidth-1:0]     pcData;
        logic [datapathPkg::dataWidth-1:0]     mdrData;
        logic [datapathPkg::dataWidth-1:0]     yData;
        logic [datapathPkg::dataWidth-1:0]     constData;
        logic [2*datapathPkg::dataWidth-1:0]   aluResult;

        // Enables in busSource order, registers in the low bits
        assign outEnable = {cOut, inPortOut, mdrOut, pcOut, zLowOut, zHighOut, loOut, hiOut,
                regOut};

        busEncoder busEncoder_inst (
                .outEnable(outEnable), .regData(regData),
                .hiData(hiData), .loData(loData), .zHigh(zHigh), .zLow(zLow),
                .pcData(pcData), .mdrData(mdrData), .inPort(inPort),
                .constData(constData), .busData(busData)
        );

        registerFile registerFile_inst (
                .Clock(Clock), .arstN(arstN), .regIn(regIn),
                .busData(busData), .regData(regData)
        );

        memoryDataRegister memoryDataRegister_inst (
                .Clock(Clock), .arstN(arstN), .mdrIn(mdrIn), .read(read),
                .memData(memData), .busData(busData), .mdrData(mdrData)
        );

        specialRegisters specialRegisters_inst (
                .Clock(Clock), .arstN(arstN), .pcIn(pcIn), .incPc(incPc),
                .irIn(irIn), .marIn(marIn), .yIn(yIn), .zIn(zIn),
                .hiIn(hiIn), .loIn(loIn), .busData(busData), .aluResult(aluResult),
                .pcData(pcData), .irData(irData), .marData(marData), .yData(yData),
                .zHigh(zHigh), .zLow(zLow), .hiData(hiData), .loData(loData),
                .constData(constData)
        );

        alu alu_inst (
                .operation(operation), .a(yData), .b(busData), .result(aluResult)
        );

endmodule

//--- testbench/datapathSteps.svh
`ifndef DATAPATH_STEPS_SVH
`define DATAPATH_STEPS_SVH

typedef enum {pcDest, irDest, marDest, yDest, hiDest, loDest} specialDest;

// Steps drive on the rising edge and return at the falling edge
task automatic clearStrobes();
        regIn <= '0;
        regOut <= '0;
        {hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut} <= '0;
        {pcIn, incPc, irIn, marIn, yIn, zIn, hiIn, loIn, mdrIn, read} <= '0;
        operation <= datapathPkg::opAdd;
endtask

task automatic beginStep();
        @(posedge Clock);
        clearStrobes();
endtask

// Source mask in bus index order
task automatic driveSources(input logic [datapathPkg::sourceCount-1:0] sources);
        regOut <= sources[datapathPkg::regCount-1:0];
        hiOut <= sources[datapathPkg::hiSrc];
        loOut <= sources[datapathPkg::loSrc];
        zHighOut <= sources[datapathPkg::zHighSrc];
        zLowOut <= sources[datapathPkg::zLowSrc];
        pcOut <= sources[datapathPkg::pcSrc];
        mdrOut <= sources[datapathPkg::mdrSrc];
        inPortOut <= sources[datapathPkg::inPortSrc];
        cOut <= sources[datapathPkg::constSrc];
endtask

task automatic idleStep();
        beginStep();
        @(negedge Clock);
endtask

task automatic readBus(input logic [datapathPkg::sourceCount-1:0] sources,
                output logic [datapathPkg::dataWidth-1:0] value);
        beginStep();
        driveSources(sources);
        @(negedge Clock);
        value = busData;
endtask

task automatic loadRegister(input logic [datapathPkg::sourceCount-1:0] sources,
                input int index);
        beginStep();
        driveSources(sources);
        regIn <= 16'd1 << index;
        @(negedge Clock);
endtask

task automatic loadSpecial(input logic [datapathPkg::sourceCount-1:0] sources,
                input specialDest dest);
        beginStep();
        driveSources(sources);
        case (dest)
                pcDest:  pcIn <= 1'b1;
                irDest:  irIn <= 1'b1;
                marDest: marIn <= 1'b1;
                yDest:   yIn <= 1'b1;
                hiDest:  hiIn <= 1'b1;
                default: loIn <= 1'b1;
        endcase
        @(negedge Clock);
endtask

// Memory word into MDR
task automatic fetchWord(input logic [datapathPkg::dataWidth-1:0] word);
        beginStep();
        memData <= word;
        read <= 1'b1;
        mdrIn <= 1'b1;
        @(negedge Clock);
endtask

// Second half of an ALU step, Y already holds operand a
task automatic aluStep(input logic [datapathPkg::sourceCount-1:0] sources,
                input datapathPkg::aluOp op);
        beginStep();
        driveSources(sources);
        operation <= op;
        zIn <= 1'b1;
        @(negedge Clock);
endtask

task automatic incrementPc();
        beginStep();
        incPc <= 1'b1;
        @(negedge Clock);
endtask

task automatic presentInPort(input logic [datapathPkg::dataWidth-1:0] word);
        beginStep();
        inPort <= word;
        @(negedge Clock);
endtask

`endif

//--- testbench/datapathTb.sv
`timescale 1ns/1ns

module datapathTb;

        logic                              Clock = 1'b0;
        logic                              arstN;
        logic [datapathPkg::regCount-1:0]  regIn;
        logic [datapathPkg::regCount-1:0]  regOut;
        logic                              hiOut, loOut, zHighOut, zLowOut;
        logic                              pcOut, mdrOut, inPortOut, cOut;
        logic                              pcIn, incPc, irIn, marIn, yIn, zIn;
        logic                              hiIn, loIn, mdrIn, read;
        datapathPkg::aluOp                 operation;
        logic [datapathPkg::dataWidth-1:0] memData;
        logic [datapathPkg::dataWidth-1:0] inPort;
        logic [datapathPkg::dataWidth-1:0] busData;
        logic [datapathPkg::dataWidth-1:0] marData;
        logic [datapathPkg::dataWidth-1:0] irData;

        datapath datapath_inst (
                .Clock(Clock), .arstN(arstN), .regIn(regIn), .regOut(regOut),
                .hiOut(hiOut), .loOut(loOut), .zHighOut(zHighOut), .zLowOut(zLowOut),
                .pcOut(pcOut), .mdrOut(mdrOut), .inPortOut(inPortOut), .cOut(cOut),
                .pcIn(pcIn), .incPc(incPc), .irIn(irIn), .marIn(marIn), .yIn(yIn),
                .zIn(zIn), .hiIn(hiIn), .loIn(loIn), .mdrIn(mdrIn), .read(read),
                .operation(operation), .memData(memData), .inPort(inPort),
                .busData(busData), .marData(marData), .irData(irData)
        );

        always #10 Clock = ~Clock;

        `include "datapathSteps.svh"

        function automatic logic [datapathPkg::sourceCount-1:0] sourceBit(
                        input datapathPkg::busSource source);
                return 24'd1 << source;
        endfunction

        function automatic logic [datapathPkg::sourceCount-1:0] regBit(input int index);
                return 24'd1 << index;
        endfunction

        // Expected low word with neg and not on the bus operand
        function automatic logic [31:0] expectedWord(input datapathPkg::aluOp op,
                        input logic [31:0] a, input logic [31:0] b);
                case (op)
                        datapathPkg::opAdd: return a + b;
                        datapathPkg::opSub: return a - b;
                        datapathPkg::opAnd: return a & b;
                        datapathPkg::opOr:  return a | b;
                        datapathPkg::opShl: return a << b[4:0];
                        datapathPkg::opShr: return a >> b[4:0];
                        datapathPkg::opNeg: return -b;
                        datapathPkg::opNot: return ~b;
                        default:            return '0;
                endcase
        endfunction

        task automatic reportFailure();
                $display("tests failed");
                $fatal(1);
        endtask

        task automatic checkWord(input string testName, input logic [31:0] expected,
                        input logic [31:0] actual);
                assert (actual === expected) else begin
                        $display("error %s expected %h actual %h", testName, expected, actual);
                        reportFailure();
                end
        endtask

        initial begin
                logic [31:0]       a;
                logic [31:0]       b;
                logic [31:0]       word;
                logic [31:0]       value;
                logic [63:0]       product;
                int                index;
                int                count;
                datapathPkg::aluOp ops [0:7];

                void'($urandom(32'h1e76_3f24));
                ops = '{datapathPkg::opAdd, datapathPkg::opSub, datapathPkg::opAnd,
                        datapathPkg::opOr, datapathPkg::opShl, datapathPkg::opShr,
                        datapathPkg::opNeg, datapathPkg::opNot};
                clearStrobes();
                arstN <= 1'b0;
                memData <= '0;
                inPort <= '0;
                repeat (10) @(posedge Clock);
                arstN <= 1'b1;

                // Idle bus and cleared registers
                idleStep();
                checkWord("reset bus idle", 32'd0, busData);
                readBus(sourceBit(datapathPkg::pcSrc), value);
                checkWord("reset pc", 32'd0, value);
                for (int i = 0; i < datapathPkg::regCount; i++) begin
                        readBus(regBit(i), value);
                        checkWord("reset register", 32'd0, value);
                end

                // Memory word through MDR into a register
                word = $urandom;
                index = int'($urandom % 16);
                fetchWord(word);
                loadRegister(sourceBit(datapathPkg::mdrSrc), index);
                readBus(regBit(index), value);
                checkWord("register load", word, value);
                b = ~word;
                fetchWord(b);
                readBus(regBit(index) | sourceBit(datapathPkg::mdrSrc), value);
                checkWord("priority register over mdr", word, value);
                readBus(sourceBit(datapathPkg::mdrSrc) | sourceBit(datapathPkg::constSrc), value);
                checkWord("priority mdr over const", b, value);

                for (int k = 0; k < 8; k++) begin
                        a = $urandom;
                        b = $urandom;
                        fetchWord(a);
                        loadRegister(sourceBit(datapathPkg::mdrSrc), 1);
                        fetchWord(b);
                        loadRegister(sourceBit(datapathPkg::mdrSrc), 2);
                        loadSpecial(sourceBit(datapathPkg::r1Src), yDest);
                        aluStep(sourceBit(datapathPkg::r2Src), ops[k]);
                        readBus(sourceBit(datapathPkg::zLowSrc), value);
                        checkWord(ops[k].name(), expectedWord(ops[k], a, b), value);
                        readBus(sourceBit(datapathPkg::zHighSrc), value);
                        checkWord("alu high word", 32'd0, value);
                end

                // Signed multiply with mixed and negative operands
                for (int k = 0; k < 3; k++) begin
                        a = $urandom;
                        b = $urandom & 32'h7fff_ffff;
                        if (k > 0) begin
                                a = a | 32'h8000_0000;
                        end
                        if (k > 1) begin
                                b = b | 32'h8000_0000;
                        end
                        product = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                        fetchWord(a);
                        loadRegister(sourceBit(datapathPkg::mdrSrc), 3);
                        fetchWord(b);
                        loadRegister(sourceBit(datapathPkg::mdrSrc), 4);
                        loadSpecial(sourceBit(datapathPkg::r3Src), yDest);
                        aluStep(sourceBit(datapathPkg::r4Src), datapathPkg::opMul);
                        loadSpecial(sourceBit(datapathPkg::zLowSrc), loDest);
                        loadSpecial(sourceBit(datapathPkg::zHighSrc), hiDest);
                        readBus(sourceBit(datapathPkg::loSrc), value);
                        checkWord("mul low", product[31:0], value);
                        readBus(sourceBit(datapathPkg::hiSrc), value);
                        checkWord("mul high", product[63:32], value);
                end

                count = 3 + int'($urandom % 6);
                repeat (count) incrementPc();
                readBus(sourceBit(datapathPkg::pcSrc), value);
                checkWord("pc count", count, value);
                loadSpecial(sourceBit(datapathPkg::pcSrc), marDest);
                idleStep();
                checkWord("mar from pc", count, marData);

                // Immediate with the sign bit set and then clear
                for (int k = 0; k < 2; k++) begin
                        word = $urandom;
                        word[18] = (k == 0);
                        fetchWord(word);
                        loadSpecial(sourceBit(datapathPkg::mdrSrc), irDest);
                        idleStep();
                        checkWord("ir load", word, irData);
                        readBus(sourceBit(datapathPkg::constSrc), value);
                        checkWord("immediate", {{13{word[18]}}, word[18:0]}, value);
                end

                word = $urandom;
                index = int'($urandom % 16);
                presentInPort(word);
                readBus(sourceBit(datapathPkg::inPortSrc), value);
                checkWord("in port bus", word, value);
                loadRegister(sourceBit(datapathPkg::inPortSrc), index);
                readBus(regBit(index), value);
                checkWord("in port register", word, value);

                $display("all tests passed");
                $finish;
        end

endmodule

//--- datapath.f
+incdir+testbench
hw/datapathPkg.sv
hw/registerFile.sv
hw/busEncoder.sv
hw/memoryDataRegister.sv
hw/specialRegisters.sv
hw/alu.sv
hw/datapath.sv
testbench/datapathTb.sv

//--- run.sh
#!/bin/sh
# Build the datapath testbench with Verilator, run it, and look for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module datapathTb -f datapath.f \
        && ./obj_dir/VdatapathTb | tee /dev/stderr | grep "all tests passed" > /dev/null \
        && echo "PASS" \
        || { echo "FAIL"; exit 1; }
